/* mem_server_top.f */
src/mem_server_pkg.sv
src/mem_req_if.sv
src/uart_link.sv
src/request_decode.sv
src/memory_execute.sv
src/response_frame.sv
src/mem_server_top.sv
verification/tb_clock_gen.sv
verification/mem_server_tb.sv

/* Bender.yml */
package:
  name: mem_server

sources:
  - src/mem_server_pkg.sv
  - src/mem_req_if.sv
  - src/uart_link.sv
  - src/request_decode.sv
  - src/memory_execute.sv
  - src/response_frame.sv
  - src/mem_server_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/mem_server_tb.sv

/* verification/mem_server_tb.sv */
module mem_server_tb import mem_server_pkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 3;
	localparam int CLKS_PER_BIT = 4;
	localparam int MEM_BYTES = 1024;
	// Requests plus responses over all tests, rounded up
	localparam int NUM_FRAMES = 64;
	localparam int CYCLE_LIMIT = NUM_FRAMES * 10 * CLKS_PER_BIT * (MAX_PAYLOAD + 1) * 2;

	logic       clk;
	logic       rst;
	logic       rx;
	logic       tx;
	logic [7:0] ref_mem [MEM_BYTES];
	logic [7:0] raw_frame [MAX_PAYLOAD + 1];
	logic [7:0] tx_bytes [$];
	int         error_count = 0;
	int         pass_tests = 0;
	int         fail_tests = 0;
	int         cycle_count = 0;
	int         seed_value;

	tb_clock_gen #(
		.PERIOD       (CLK_PERIOD),
		.RESET_CYCLES (RESET_CYCLES)
	) u_clock (
		.clk (clk),
		.rst (rst)
	);

	mem_server_top #(
		.CLKS_PER_BIT (CLKS_PER_BIT),
		.MEM_BYTES    (MEM_BYTES)
	) uut (
		.clk (clk),
		.rst (rst),
		.rx  (rx),
		.tx  (tx)
	);

	////////////////////////////////////////
	// Checks and reference model
	////////////////////////////////////////

	task automatic check_value(input string test_name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			error_count++;
			$display("[FAIL] %s: expected 0x%08h, actual 0x%08h", test_name, expected, actual);
		end
	endtask

	task automatic finish_test(input string test_name, input int errors_at_start);
		if (error_count == errors_at_start) begin
			pass_tests++;
			$display("Test %s: ok", test_name);
		end else begin
			fail_tests++;
			$display("Test %s: failed with %0d errors", test_name, error_count - errors_at_start);
		end
	endtask

	// Lanes land at addr + k, wrapped to the memory size
	task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] mask);
		for (int k = 0; k < 4; k++) begin
			if (mask[k])
				ref_mem[(addr + 32'(k)) % MEM_BYTES] = data[8*k +: 8];
		end
	endtask

	function automatic logic [31:0] model_read(input logic [31:0] addr);
		logic [31:0] word;
		for (int k = 0; k < 4; k++) begin
			word[8*k +: 8] = ref_mem[(addr + 32'(k)) % MEM_BYTES];
		end
		return word;
	endfunction

	////////////////////////////////////////
	// UART host model
	////////////////////////////////////////

	// Start bit, eight data bits LSB first, stop bit
	task automatic send_byte(input logic [7:0] value);
		logic [9:0] bits;
		bits = {1'b1, value, 1'b0};
		for (int i = 0; i < 10; i++) begin
			rx <= bits[i];
			repeat (CLKS_PER_BIT) @(posedge clk);
		end
	endtask

	task automatic send_raw(input int num_bytes);
		for (int i = 0; i < num_bytes; i++) begin
			send_byte(raw_frame[i]);
		end
	endtask

	task automatic send_read(input logic [31:0] addr);
		send_byte(LEN_READ_REQ);
		for (int k = 0; k < 4; k++) begin
			send_byte(addr[8*k +: 8]);
		end
		send_byte(8'h00);
	endtask

	task automatic send_write(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] mask);
		send_byte(LEN_WRITE_REQ);
		for (int k = 0; k < 4; k++) begin
			send_byte(addr[8*k +: 8]);
		end
		for (int k = 0; k < 4; k++) begin
			send_byte(data[8*k +: 8]);
		end
		send_byte({4'h0, mask});
	endtask

	// Samples on falling clock edges, near the middle of each bit
	task automatic recv_byte(output logic [7:0] data);
		@(negedge tx);
		repeat (CLKS_PER_BIT / 2) @(negedge clk);
		if (tx !== 1'b0) begin
			error_count++;
			$display("Start bit on tx did not stay low");
		end
		for (int i = 0; i < 8; i++) begin
			repeat (CLKS_PER_BIT) @(negedge clk);
			data[i] = tx;
		end
		repeat (CLKS_PER_BIT) @(negedge clk);
		if (tx !== 1'b1) begin
			error_count++;
			$display("Stop bit on tx was not high");
		end
	endtask

	// Whole response frame: length byte then four data bytes
	task automatic expect_response(input string test_name, input logic [31:0] expected);
		logic [31:0] word;
		while (tx_bytes.size() < 5)
			@(posedge clk);
		check_value(test_name, LEN_READ_RSP, tx_bytes.pop_front());
		for (int k = 0; k < 4; k++) begin
			word[8*k +: 8] = tx_bytes.pop_front();
		end
		check_value(test_name, expected, word);
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic test_reset_state();
		int          errors_at_start;
		logic [31:0] addr;
		errors_at_start = error_count;
		repeat (20) begin
			@(negedge clk);
			check_value("reset_state", 32'd1, {31'd0, tx});
		end
		@(posedge clk);
		addr = $urandom;
		send_read(addr);
		expect_response("reset_state", 32'h0000_0000);
		finish_test("reset_state", errors_at_start);
	endtask

	task automatic test_full_write_read();
		int          errors_at_start;
		logic [31:0] addr;
		logic [31:0] data;
		errors_at_start = error_count;
		addr = $urandom;
		data = $urandom;
		send_write(addr, data, 4'hF);
		model_write(addr, data, 4'hF);
		send_read(addr);
		expect_response("full_write_read", data);
		finish_test("full_write_read", errors_at_start);
	endtask

	task automatic test_partial_mask();
		int          errors_at_start;
		logic [31:0] addr;
		logic [31:0] data;
		errors_at_start = error_count;
		addr = $urandom;
		data = $urandom;
		send_write(addr, 32'hFFFF_FFFF, 4'hF);
		model_write(addr, 32'hFFFF_FFFF, 4'hF);
		// Lanes 0 and 2 only
		send_write(addr, data, 4'b0101);
		model_write(addr, data, 4'b0101);
		send_read(addr);
		expect_response("partial_mask", {8'hFF, data[23:16], 8'hFF, data[7:0]});
		finish_test("partial_mask", errors_at_start);
	endtask

	task automatic test_wraparound();
		int          errors_at_start;
		logic [31:0] data;
		logic [31:0] high_addr;
		errors_at_start = error_count;
		data = $urandom;
		send_write(32'(MEM_BYTES - 2), data, 4'hF);
		model_write(32'(MEM_BYTES - 2), data, 4'hF);
		send_read(32'(MEM_BYTES - 2));
		expect_response("wraparound", model_read(32'(MEM_BYTES - 2)));
		send_read(32'h0000_0000);
		expect_response("wraparound", model_read(32'h0000_0000));
		// Far above the memory, lands at 0x208
		high_addr = 32'hC000_0208;
		data = $urandom;
		send_write(high_addr, data, 4'hF);
		model_write(high_addr, data, 4'hF);
		send_read(32'h0000_0208);
		expect_response("wraparound", data);
		finish_test("wraparound", errors_at_start);
	endtask

	task automatic test_malformed_frames();
		int          errors_at_start;
		logic [31:0] addr;
		errors_at_start = error_count;
		// Length 7, payload avoids the values 5 and 9
		raw_frame[0] = 8'd7;
		for (int i = 1; i < 8; i++) begin
			raw_frame[i] = 8'hA0 + 8'(i);
		end
		send_raw(8);
		// Read frame with a nonzero fifth byte
		addr = $urandom;
		raw_frame[0] = LEN_READ_REQ;
		for (int k = 0; k < 4; k++) begin
			raw_frame[k + 1] = addr[8*k +: 8];
		end
		raw_frame[5] = 8'h01;
		send_raw(6);
		repeat (600) @(posedge clk);
		check_value("malformed_frames", 32'd0, tx_bytes.size());
		send_read(addr);
		expect_response("malformed_frames", model_read(addr));
		finish_test("malformed_frames", errors_at_start);
	endtask

	task automatic test_random_traffic();
		int          errors_at_start;
		logic [31:0] addr;
		logic [31:0] data;
		logic [3:0]  mask;
		logic [31:0] expected_q [$];
		errors_at_start = error_count;
		// Requests stream back to back, responses are checked in order afterwards
		for (int i = 0; i < 20; i++) begin
			addr = $urandom;
			data = $urandom;
			mask = 4'($urandom);
			if ($urandom % 2 == 0) begin
				send_read(addr);
				expected_q.push_back(model_read(addr));
			end else begin
				send_write(addr, data, mask);
				model_write(addr, data, mask);
			end
		end
		while (expected_q.size() > 0)
			expect_response("random_traffic", expected_q.pop_front());
		repeat (600) @(posedge clk);
		check_value("random_traffic", 32'd0, tx_bytes.size());
		finish_test("random_traffic", errors_at_start);
	endtask

	////////////////////////////////////////
	// Run control
	////////////////////////////////////////

	initial begin : tx_monitor
		logic [7:0] line_byte;
		wait (rst === 1'b0);
		forever begin
			recv_byte(line_byte);
			tx_bytes.push_back(line_byte);
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Verification failed");
			$finish;
		end
	end

	initial begin
		rx = 1'b1;
		seed_value = $urandom(96407);
		for (int i = 0; i < MEM_BYTES; i++) begin
			ref_mem[i] = 8'h00;
		end
		@(posedge clk);
		while (rst)
			@(posedge clk);
		test_reset_state();
		test_full_write_read();
		test_partial_mask();
		test_wraparound();
		test_malformed_frames();
		test_random_traffic();
		$display("Tests passed: %0d, failed: %0d", pass_tests, fail_tests);
		if (fail_tests == 0 && error_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* verification/tb_clock_gen.sv */
module tb_clock_gen #(
	parameter int PERIOD = 40,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Reset held over the first few rising edges
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

/* src/mem_server_top.sv */
module mem_server_top #(
	parameter int CLKS_PER_BIT = 4,
	parameter int MEM_BYTES = 1024
) (
	input  logic clk,
	input  logic rst,
	input  logic rx,
	output logic tx
);

	logic        rx_valid;
	logic [7:0]  rx_byte;
	logic        tx_valid;
	logic        tx_ready;
	logic [7:0]  tx_byte;
	logic        rsp_valid;
	logic        rsp_ready;
	logic [31:0] rsp_data;

	mem_req_if req_bus ();

	////////////////////////////////////////
	// Serial side
	////////////////////////////////////////

	uart_link #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_link (
		.clk      (clk),
		.rst      (rst),
		.rx       (rx),
		.tx       (tx),
		.rx_valid (rx_valid),
		.rx_byte  (rx_byte),
		.tx_valid (tx_valid),
		.tx_byte  (tx_byte),
		.tx_ready (tx_ready)
	);

	////////////////////////////////////////
	// Decode, execute, result
	////////////////////////////////////////

	request_decode u_decode (
		.clk      (clk),
		.rst      (rst),
		.rx_valid (rx_valid),
		.rx_byte  (rx_byte),
		.req      (req_bus.decoder)
	);

	memory_execute #(
		.MEM_BYTES(MEM_BYTES)
	) u_execute (
		.clk       (clk),
		.rst       (rst),
		.req       (req_bus.executor),
		.rsp_valid (rsp_valid),
		.rsp_data  (rsp_data),
		.rsp_ready (rsp_ready)
	);

	response_frame u_result (
		.clk       (clk),
		.rst       (rst),
		.rsp_valid (rsp_valid),
		.rsp_data  (rsp_data),
		.rsp_ready (rsp_ready),
		.tx_valid  (tx_valid),
		.tx_byte   (tx_byte),
		.tx_ready  (tx_ready)
	);

endmodule

/* src/response_frame.sv */
module response_frame import mem_server_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        rsp_valid,
	input  logic [31:0] rsp_data,
	output logic        rsp_ready,
	output logic        tx_valid,
	output logic [7:0]  tx_byte,
	input  logic        tx_ready
);

	result_state_t state;
	logic [31:0]   rsp_word;
	logic [1:0]    byte_idx;
	logic          tx_hs;

	assign rsp_ready = (state == RS_IDLE);
	assign tx_valid  = (state != RS_IDLE);
	assign tx_hs     = tx_valid && tx_ready;

	// Length byte first, then data LSB first
	assign tx_byte = (state == RS_LEN) ? LEN_READ_RSP : rsp_word[8*byte_idx +: 8];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= RS_IDLE;
			byte_idx <= '0;
		end else begin
			case (state)
				RS_IDLE: begin
					byte_idx <= '0;
					if (rsp_valid)
						state <= RS_LEN;
				end
				RS_LEN: begin
					if (tx_hs)
						state <= RS_DATA;
				end
				RS_DATA: begin
					if (tx_hs) begin
						byte_idx <= byte_idx + 2'd1;
						if (byte_idx == 2'(LEN_READ_RSP - 8'd1))
							state <= RS_IDLE;
					end
				end
				default: state <= RS_IDLE;
			endcase
		end
	end

	// Word is held here so execute can take the next request
	always_ff @(posedge clk) begin
		if (rsp_valid && rsp_ready)
			rsp_word <= rsp_data;
	end

endmodule

/* src/memory_execute.sv */
module memory_execute import mem_server_pkg::*; #(
	parameter int MEM_BYTES = 1024
) (
	input  logic        clk,
	input  logic        rst,
	mem_req_if.executor req,
	output logic        rsp_valid,
	output logic [31:0] rsp_data,
	input  logic        rsp_ready
);

	localparam int ADDR_W = $clog2(MEM_BYTES);

	logic [7:0]        mem [MEM_BYTES];
	logic [ADDR_W-1:0] lane_addr [4];
	logic              req_hs;
	logic              rd_hs;
	logic              wr_hs;

	// One outstanding read at most
	assign req.ready = !rsp_valid;
	assign req_hs    = req.valid && req.ready;
	assign rd_hs     = req_hs && (req.op == OP_READ);
	assign wr_hs     = req_hs && (req.op == OP_WRITE);

	// Lane addresses wrap inside the array
	always_comb begin
		for (int k = 0; k < 4; k++) begin
			lane_addr[k] = req.addr[ADDR_W-1:0] + ADDR_W'(k);
		end
	end

	////////////////////////////////////////
	// Storage
	////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < MEM_BYTES; i++) begin
				mem[i] <= 8'h00;
			end
		end else if (wr_hs) begin
			for (int k = 0; k < 4; k++) begin
				if (req.mask[k])
					mem[lane_addr[k]] <= req.wdata[8*k +: 8];
			end
		end
	end

	////////////////////////////////////////
	// Read response
	////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			rsp_valid <= 1'b0;
		else if (rsp_valid && rsp_ready)
			rsp_valid <= 1'b0;
		else if (rd_hs)
			rsp_valid <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rd_hs)
			rsp_data <= {mem[lane_addr[3]], mem[lane_addr[2]],
				mem[lane_addr[1]], mem[lane_addr[0]]};
	end

	// An offered request must carry fully built fields
	assert property (@(posedge clk) disable iff (rst)
		req.valid |-> !$isunknown({req.op, req.addr, req.wdata, req.mask}))
		else $error("request offered with unknown fields");

endmodule

/* src/request_decode.sv */
module request_decode import mem_server_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       rx_valid,
	input  logic [7:0] rx_byte,
	mem_req_if.decoder req
);

	decode_state_t state;
	logic [7:0]    payload [MAX_PAYLOAD];
	logic [3:0]    idx;
	logic [3:0]    last_idx;
	logic          is_read;
	logic          last_byte;

	assign req.valid = (state == DS_ISSUE);
	assign last_byte = (state == DS_PAYLOAD) && rx_valid && (idx == last_idx);

	////////////////////////////////////////
	// Frame FSM
	////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= DS_LEN;
			idx      <= '0;
			last_idx <= '0;
			is_read  <= 1'b0;
		end else begin
			case (state)
				DS_LEN: begin
					if (rx_valid) begin
						idx      <= '0;
						last_idx <= rx_byte[3:0] - 4'd1;
						is_read  <= (rx_byte == LEN_READ_REQ);
						// Unknown lengths never leave this state
						if (rx_byte == LEN_READ_REQ || rx_byte == LEN_WRITE_REQ)
							state <= DS_PAYLOAD;
					end
				end
				DS_PAYLOAD: begin
					if (rx_valid) begin
						idx <= idx + 4'd1;
						if (idx == last_idx) begin
							// Read frames need a zero fifth byte
							if (is_read && rx_byte != 8'd0)
								state <= DS_LEN;
							else
								state <= DS_ISSUE;
						end
					end
				end
				DS_ISSUE: begin
					// Bytes arriving here are lost
					if (req.ready)
						state <= DS_LEN;
				end
				default: state <= DS_LEN;
			endcase
		end
	end

	////////////////////////////////////////
	// Payload buffer and request fields
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (state == DS_PAYLOAD && rx_valid)
			payload[idx] <= rx_byte;
		if (last_byte) begin
			req.addr <= {payload[3], payload[2], payload[1], payload[0]};
			if (is_read) begin
				req.op    <= OP_READ;
				req.wdata <= '0;
				req.mask  <= 4'h0;
			end else begin
				req.op    <= OP_WRITE;
				req.wdata <= {payload[7], payload[6], payload[5], payload[4]};
				// Mask is the ninth byte, taken straight off the line
				req.mask  <= rx_byte[3:0];
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		req.valid && !req.ready |=> req.valid && $stable(req.op) && $stable(req.addr)
			&& $stable(req.wdata) && $stable(req.mask))
		else $error("request changed while waiting for execute");

endmodule

/* src/uart_link.sv */
module uart_link import mem_server_pkg::*; #(
	parameter int CLKS_PER_BIT = 4
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       rx,
	output logic       tx,
	output logic       rx_valid,
	output logic [7:0] rx_byte,
	input  logic       tx_valid,
	input  logic [7:0] tx_byte,
	output logic       tx_ready
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
	localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'((CLKS_PER_BIT - 1) / 2);

	logic             rx_meta;
	logic             rx_sync;
	uart_state_t      rx_state;
	logic [CNT_W-1:0] rx_cnt;
	logic [2:0]       rx_bit;
	logic [7:0]       rx_shift;
	logic             rx_sample;

	uart_state_t      tx_state;
	logic [CNT_W-1:0] tx_cnt;
	logic [2:0]       tx_bit;
	logic [7:0]       tx_shift;
	logic             tx_load;
	logic             tx_step;

	////////////////////////////////////////
	// Receiver
	////////////////////////////////////////

	// Two-flop synchronizer, idles high like the line
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	assign rx_sample = (rx_state == US_DATA) && (rx_cnt == BIT_LAST);
	assign rx_byte = rx_shift;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rx_state <= US_IDLE;
			rx_cnt   <= '0;
			rx_bit   <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (rx_state)
				US_IDLE: begin
					rx_cnt <= '0;
					if (!rx_sync)
						rx_state <= US_START;
				end
				US_START: begin
					// Middle of start bit; a short glitch goes back to idle
					if (rx_cnt == HALF_BIT) begin
						rx_cnt   <= '0;
						rx_bit   <= '0;
						rx_state <= rx_sync ? US_IDLE : US_DATA;
					end else begin
						rx_cnt <= rx_cnt + 1'b1;
					end
				end
				US_DATA: begin
					if (rx_cnt == BIT_LAST) begin
						rx_cnt <= '0;
						rx_bit <= rx_bit + 1'b1;
						if (rx_bit == 3'd7)
							rx_state <= US_STOP;
					end else begin
						rx_cnt <= rx_cnt + 1'b1;
					end
				end
				US_STOP: begin
					if (rx_cnt == BIT_LAST) begin
						rx_valid <= rx_sync;  // framing error drops the byte
						rx_state <= US_IDLE;
					end else begin
						rx_cnt <= rx_cnt + 1'b1;
					end
				end
				default: rx_state <= US_IDLE;
			endcase
		end
	end

	// LSB first, so shift in from the top
	always_ff @(posedge clk) begin
		if (rx_sample)
			rx_shift <= {rx_sync, rx_shift[7:1]};
	end

	////////////////////////////////////////
	// Transmitter
	////////////////////////////////////////

	assign tx_ready = (tx_state == US_IDLE);
	assign tx_load  = tx_valid && tx_ready;
	assign tx_step  = (tx_state == US_DATA) && (tx_cnt == BIT_LAST);

	always_comb begin
		case (tx_state)
			US_START: tx = 1'b0;
			US_DATA:  tx = tx_shift[0];
			default:  tx = 1'b1;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			tx_state <= US_IDLE;
			tx_cnt   <= '0;
			tx_bit   <= '0;
		end else begin
			case (tx_state)
				US_IDLE: begin
					tx_cnt <= '0;
					tx_bit <= '0;
					if (tx_valid)
						tx_state <= US_START;
				end
				US_START: begin
					if (tx_cnt == BIT_LAST) begin
						tx_cnt   <= '0;
						tx_state <= US_DATA;
					end else begin
						tx_cnt <= tx_cnt + 1'b1;
					end
				end
				US_DATA: begin
					if (tx_cnt == BIT_LAST) begin
						tx_cnt <= '0;
						tx_bit <= tx_bit + 1'b1;
						if (tx_bit == 3'd7)
							tx_state <= US_STOP;
					end else begin
						tx_cnt <= tx_cnt + 1'b1;
					end
				end
				US_STOP: begin
					if (tx_cnt == BIT_LAST)
						tx_state <= US_IDLE;
					else
						tx_cnt <= tx_cnt + 1'b1;
				end
				default: tx_state <= US_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (tx_load)
			tx_shift <= tx_byte;
		else if (tx_step)
			tx_shift <= {1'b0, tx_shift[7:1]};
	end

	// Sender keeps the byte on offer until the line goes idle
	assert property (@(posedge clk) disable iff (rst)
		tx_valid && !tx_ready |=> tx_valid && $stable(tx_byte))
		else $error("tx byte withdrawn before it was accepted");

endmodule

/* src/mem_req_if.sv */
interface mem_req_if import mem_server_pkg::*; ();

	// One decoded request, held until ready
	logic        valid;
	logic        ready;
	mem_op_t     op;
	logic [31:0] addr;
	logic [31:0] wdata;
	logic [3:0]  mask;

	modport decoder (
		output valid,
		output op,
		output addr,
		output wdata,
		output mask,
		input  ready
	);

	modport executor (
		input  valid,
		input  op,
		input  addr,
		input  wdata,
		input  mask,
		output ready
	);

endinterface

/* src/mem_server_pkg.sv */
package mem_server_pkg;

	////////////////////////////////////////
	// Frame constants
	////////////////////////////////////////

	// Read request: addr[4] then a zero byte
	localparam logic [7:0] LEN_READ_REQ = 8'd5;

	// Write request: addr[4], data[4], lane mask
	localparam logic [7:0] LEN_WRITE_REQ = 8'd9;

	// Response: four data bytes
	localparam logic [7:0] LEN_READ_RSP = 8'd4;

	// Largest payload the frame buffer must hold
	localparam int MAX_PAYLOAD = 9;

	////////////////////////////////////////
	// Opcodes and FSM states
	////////////////////////////////////////

	typedef enum logic {
		OP_READ,
		OP_WRITE
	} mem_op_t;

	typedef enum logic [1:0] {
		DS_LEN,
		DS_PAYLOAD,
		DS_ISSUE
	} decode_state_t;

	typedef enum logic [1:0] {
		RS_IDLE,
		RS_LEN,
		RS_DATA
	} result_state_t;

	typedef enum logic [1:0] {
		US_IDLE,
		US_START,
		US_DATA,
		US_STOP
	} uart_state_t;

endpackage
